// ==== testbench/router_golden.txt ====
# router vectors, one command per line, all numbers hex
# w name addr data | r name addr value | p name in n bytes | e name out n bytes
r rst_in0 36 0
r rst_size 32 0
p dis_in0 0 0e 01 02 0e 00 00 00 0a 00 00 00 01 02 03 04
r dis_in0 36 0
w en_sa 20 f
w en_da 24 f
p route_0 0 0e 01 02 0e 00 00 00 a0 00 00 00 10 20 30 40
e route_0 1 0e 01 02 0e 00 00 00 a0 00 00 00 10 20 30 40
p route_1 1 0e 02 03 0e 00 00 00 aa 00 00 00 11 22 33 44
e route_1 2 0e 02 03 0e 00 00 00 aa 00 00 00 11 22 33 44
p route_2 2 10 03 04 10 00 00 00 ff 03 00 00 ff ff ff ff 01 02
e route_2 3 10 03 04 10 00 00 00 ff 03 00 00 ff ff ff ff 01 02
p route_3 3 0e 04 01 0e 00 00 00 00 02 00 00 80 80 80 80
e route_3 0 0e 04 01 0e 00 00 00 00 02 00 00 80 80 80 80
r route_in0 36 1
r route_out3 5e 1
p crc_bad 0 0e 01 02 0e 00 00 00 00 00 00 00 01 02 03 04
p len_diff 1 0e 02 03 0f 00 00 00 0a 00 00 00 01 02 03 04
p len_lo 2 0d 03 04 0d 00 00 00 06 00 00 00 01 02 03
p da_zero 3 0e 04 00 0e 00 00 00 0a 00 00 00 01 02 03 04
r crc_one 94 1
p len_hi 3 41 04 01 41 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
w da_part 24 7
p da_off 0 0e 01 04 0e 00 00 00 0a 00 00 00 01 02 03 04
w sa_part 20 e
p sa_off 1 0e 01 03 0e 00 00 00 0a 00 00 00 01 02 03 04
w en_sa 20 f
w en_da 24 f
p cont_a 0 0e 01 02 0e 00 00 00 1a 00 00 00 05 06 07 08
p cont_b 2 0e 03 02 0e 00 00 00 2a 00 00 00 09 0a 0b 0c
e cont_a 1 0e 01 02 0e 00 00 00 1a 00 00 00 05 06 07 08
e cont_b 1 0e 03 02 0e 00 00 00 2a 00 00 00 09 0a 0b 0c
r in_cnt0 36 4
r in_cnt1 3a 3
r in_cnt2 3e 3
r in_cnt3 42 3
r out_cnt0 52 1
r out_cnt1 56 3
r out_cnt2 5a 1
r out_cnt3 5e 1
r size_drops 32 3
r da_drops 66 2
r sa_drops 70 1
r crc_drops 94 1

// ==== project.f ====
rtl/router_pkt_pkg.sv
rtl/router_csr_pkg.sv
rtl/packet_receiver.sv
rtl/packet_store.sv
rtl/switch_fabric.sv
rtl/router_csr.sv
rtl/router_top.sv
testbench/router_assertions.sv
testbench/router_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the router testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module router_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vrouter_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Finished with no errors"; then
   exit 0
else
   exit 1
fi

// ==== testbench/router_tb.sv ====
/*
 * router testbench replays golden packets on the four inputs, checks every
 * output byte under random back-pressure and reads back the counters
 */
`timescale 1ns/1ps

module router_tb
   import router_pkt_pkg::*;
   import router_csr_pkg::*;
();

   localparam int          TIMEOUT = 4000;   // cycles per wait
   localparam int          MAX_EXP = 16;
   localparam logic [31:0] SEED    = 32'd59369;

   logic        clk = 1'b0;
   logic        reset;
   pkt_beat_t   in_beat [NUM_PORTS] = '{default: '0};
   port_mask_t  in_valid = '0;
   port_mask_t  in_ready;
   pkt_beat_t   out_beat [NUM_PORTS];
   port_mask_t  out_valid;
   port_mask_t  out_ready = '0;
   csr_req_t    csr_req;
   logic [31:0] rdata;

   pkt_beat_t   in_q [NUM_PORTS][$];   // bytes still to send per input
   port_mask_t  taken = '0;
   logic        run = 1'b0;
   logic [31:0] rnd = SEED;

   // expected output packets are matched on arrival by their first byte
   logic [7:0]  exp_data [MAX_EXP][MAX_PKT_LEN];
   int          exp_len [MAX_EXP];
   int          exp_port [MAX_EXP];
   string       exp_name [MAX_EXP];
   logic        exp_used [MAX_EXP] = '{default: 1'b0};
   int          n_exp = 0;
   int          cur_k [NUM_PORTS] = '{default: -1};   // packet being received
   int          cur_pos [NUM_PORTS] = '{default: 0};

   router_top u_router_top (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .csr_req   (csr_req),
      .rdata     (rdata)
   );

   bind router_top router_assertions u_assertions (
      .clk       (clk),
      .reset     (reset),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_beat(string name, pkt_beat_t expected, pkt_beat_t actual);
      if (actual !== expected) begin
         fail_run($sformatf("FAIL %s expected %h/%b actual %h/%b", name,
                            expected.data, expected.last, actual.data, actual.last));
      end
   endtask

   task automatic compare_word(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
      end
   endtask

   function automatic int find_expected(int j, logic [7:0] first);
      for (int k = 0; k < n_exp; k++) begin
         if (!exp_used[k] && exp_port[k] == j && exp_data[k][0] == first) begin
            return k;
         end
      end
      return -1;
   endfunction

   task automatic collect_beat(int j, pkt_beat_t actual);
      pkt_beat_t expected;
      int        k;
      if (cur_k[j] < 0) begin
         k = find_expected(j, actual.data);
         if (k < 0) begin
            fail_run($sformatf("output %0d sent a packet that was not expected", j));
         end
         exp_used[k] = 1'b1;
         cur_k[j]    = k;
         cur_pos[j]  = 0;
      end
      k = cur_k[j];
      expected.data = exp_data[k][cur_pos[j]];
      expected.last = cur_pos[j] == exp_len[k] - 1;
      compare_beat(exp_name[k], expected, actual);
      cur_pos[j]++;
      if (actual.last) begin
         cur_k[j] = -1;
      end
   endtask

   function automatic logic all_idle();
      logic idle;
      idle = in_valid == '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (in_q[i].size() != 0 || cur_k[i] >= 0) begin
            idle = 1'b0;
         end
      end
      for (int k = 0; k < n_exp; k++) begin
         if (!exp_used[k]) begin
            idle = 1'b0;
         end
      end
      return idle;
   endfunction

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (!all_idle()) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            fail_run("timeout: traffic did not drain or an expected packet never came out");
         end
      end
      repeat (3) @(posedge clk);   // event pulse and then the counter update
   endtask

   task automatic write_reg(logic [7:0] addr, logic [31:0] data);
      @(posedge clk);
      #2;
      csr_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
      @(posedge clk);
      #2;
      csr_req = '0;
   endtask

   task automatic read_reg(string name, logic [7:0] addr, logic [31:0] expected);
      @(posedge clk);
      #2;
      csr_req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'h0};
      @(posedge clk);
      #2;
      csr_req = '0;
      compare_word(name, expected, rdata);   // registered read data
   endtask

   // handshakes sampled mid-cycle since the transfer happens at the next rising edge
   always @(negedge clk) begin
      taken = in_valid & in_ready;
      if (run) begin
         for (int j = 0; j < NUM_PORTS; j++) begin
            if (out_valid[j] && out_ready[j]) begin
               collect_beat(j, out_beat[j]);
            end
         end
      end
   end

   always @(posedge clk) begin
      #2;
      if (run) begin
         for (int i = 0; i < NUM_PORTS; i++) begin
            if (taken[i]) begin
               void'(in_q[i].pop_front());
            end
            if (in_q[i].size() > 0) begin
               in_beat[i]  = in_q[i][0];
               in_valid[i] = 1'b1;
            end else begin
               in_valid[i] = 1'b0;
            end
         end
         rnd       = xorshift(rnd);
         out_ready = rnd[3:0] | rnd[7:4];   // mostly ready
      end
   end

   initial begin
      int           fd;
      int           code;
      int           port;
      int           n;
      logic [63:0]  tok;
      logic [191:0] name_v;
      logic [799:0] line;
      logic [31:0]  a;
      logic [31:0]  v;
      logic [7:0]   byte_v;
      pkt_beat_t    b;
      string        name;
      reset   = 1'b1;
      csr_req = '0;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;
      compare_word("reset_out_valid", 32'h0, 32'(out_valid));
      compare_word("reset_in_ready", 32'({NUM_PORTS{1'b1}}), 32'(in_ready));
      run = 1'b1;
      fd = $fopen("testbench/router_golden.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open testbench/router_golden.txt");
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok == 64'("#")) begin
            code = $fgets(line, fd);
         end else begin
            code = $fscanf(fd, "%s", name_v);
            name = $sformatf("%0s", name_v);
            if (tok == 64'("w") || tok == 64'("r")) begin
               code = $fscanf(fd, "%h %h", a, v);
               if (code != 2) begin
                  fail_run("golden file has a register line without address and value");
               end
               wait_idle();
               if (tok == 64'("w")) begin
                  write_reg(a[7:0], v);
               end else begin
                  read_reg(name, a[7:0], v);
               end
            end else if (tok == 64'("p") || tok == 64'("e")) begin
               code = $fscanf(fd, "%h %h", port, n);
               if (code != 2) begin
                  fail_run("golden file has a packet line without port and length");
               end
               for (int m = 0; m < n; m++) begin
                  code = $fscanf(fd, "%h", byte_v);
                  if (code != 1) begin
                     fail_run("golden file has a packet with missing bytes");
                  end
                  if (tok == 64'("p")) begin
                     b.data = byte_v;
                     b.last = m == n - 1;
                     in_q[port].push_back(b);
                  end else begin
                     exp_data[n_exp][m] = byte_v;
                  end
               end
               if (tok == 64'("e")) begin
                  exp_port[n_exp] = port;
                  exp_len[n_exp]  = n;
                  exp_name[n_exp] = name;
                  n_exp++;
               end
            end else begin
               fail_run("unknown command in the golden file");
            end
         end
      end
      $fclose(fd);
      wait_idle();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== testbench/router_assertions.sv ====
/*
 * router handshake checks, bound into the top level
 */
`timescale 1ns/1ps

module router_assertions
   import router_pkt_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input pkt_beat_t  in_beat [NUM_PORTS],
   input port_mask_t in_valid,
   input port_mask_t in_ready,
   input pkt_beat_t  out_beat [NUM_PORTS],
   input port_mask_t out_valid,
   input port_mask_t out_ready
);

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
      out_hold: assert property (@(posedge clk) disable iff (reset)
         out_valid[i] && !out_ready[i] |=> $stable(out_beat[i]))
         else $error("out_beat %0d changed while stalled", i);

      in_hold: assert property (@(posedge clk) disable iff (reset)
         in_valid[i] && !in_ready[i] |=> $stable(in_beat[i]))
         else $error("in_beat %0d changed while stalled", i);
   end

   reset_quiet: assert property (@(posedge clk) reset |-> out_valid == '0)
      else $error("out_valid high during reset");

endmodule

// ==== rtl/router_top.sv ====
/*
 * 4x4 store-and-forward packet router with register block
 */
`timescale 1ns/1ps

module router_top
   import router_pkt_pkg::*;
   import router_csr_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  pkt_beat_t   in_beat [NUM_PORTS],
   input  port_mask_t  in_valid,
   output port_mask_t  in_ready,
   output pkt_beat_t   out_beat [NUM_PORTS],
   output port_mask_t  out_valid,
   input  port_mask_t  out_ready,
   input  csr_req_t    csr_req,
   output logic [31:0] rdata
);

   port_mask_t sa_enable;
   port_mask_t da_enable;
   port_mask_t store_full;
   port_mask_t wr_en;
   pkt_addr_t  wr_addr [NUM_PORTS];
   logic [7:0] wr_data [NUM_PORTS];
   port_mask_t commit;
   port_idx_t  commit_dest [NUM_PORTS];
   pkt_len_t   commit_len [NUM_PORTS];
   rx_event_t  rx_event [NUM_PORTS];
   pkt_beat_t  tx_beat [NUM_PORTS];
   port_mask_t tx_valid;
   port_mask_t tx_ready;
   port_idx_t  dest [NUM_PORTS];
   port_mask_t out_done;

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
      packet_receiver u_receiver (
         .clk         (clk),
         .reset       (reset),
         .in_beat     (in_beat[i]),
         .in_valid    (in_valid[i]),
         .in_ready    (in_ready[i]),
         .port_enable (sa_enable[i]),
         .sa_enable   (sa_enable),
         .da_enable   (da_enable),
         .store_full  (store_full[i]),
         .wr_en       (wr_en[i]),
         .wr_addr     (wr_addr[i]),
         .wr_data     (wr_data[i]),
         .commit      (commit[i]),
         .commit_dest (commit_dest[i]),
         .commit_len  (commit_len[i]),
         .event_out   (rx_event[i])
      );

      packet_store u_store (
         .clk         (clk),
         .reset       (reset),
         .wr_en       (wr_en[i]),
         .wr_addr     (wr_addr[i]),
         .wr_data     (wr_data[i]),
         .commit      (commit[i]),
         .commit_dest (commit_dest[i]),
         .commit_len  (commit_len[i]),
         .full        (store_full[i]),
         .dest        (dest[i]),
         .tx_beat     (tx_beat[i]),
         .tx_ready    (tx_ready[i]),
         .tx_valid    (tx_valid[i])
      );
   end

   switch_fabric u_fabric (
      .clk       (clk),
      .reset     (reset),
      .tx_beat   (tx_beat),
      .tx_valid  (tx_valid),
      .dest      (dest),
      .tx_ready  (tx_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_done  (out_done)
   );

   router_csr u_csr (
      .clk       (clk),
      .reset     (reset),
      .csr_req   (csr_req),
      .rdata     (rdata),
      .sa_enable (sa_enable),
      .da_enable (da_enable),
      .rx_event  (rx_event),
      .out_done  (out_done)
   );

endmodule

// ==== rtl/router_csr.sv ====
/*
 * router register block: port enables, packet and drop counters,
 * registered read data
 */
`timescale 1ns/1ps

module router_csr
   import router_pkt_pkg::*;
   import router_csr_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  csr_req_t    csr_req,
   output logic [31:0] rdata,
   output port_mask_t  sa_enable,
   output port_mask_t  da_enable,
   input  rx_event_t   rx_event [NUM_PORTS],
   input  port_mask_t  out_done
);

   logic [31:0] in_count [NUM_PORTS];
   logic [31:0] out_count [NUM_PORTS];
   logic [31:0] size_drop;
   logic [31:0] da_drop;
   logic [31:0] sa_drop;
   logic [31:0] crc_drop;

   logic [2:0]  n_size;   // drops of one kind seen this cycle
   logic [2:0]  n_da;
   logic [2:0]  n_sa;
   logic [2:0]  n_crc;
   logic [31:0] rd_value;

   always_comb begin
      n_size = '0;
      n_da   = '0;
      n_sa   = '0;
      n_crc  = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         n_size = n_size + 3'(rx_event[i].size_drop);
         n_da   = n_da + 3'(rx_event[i].da_drop);
         n_sa   = n_sa + 3'(rx_event[i].sa_drop);
         n_crc  = n_crc + 3'(rx_event[i].crc_drop);
      end
   end

   always_comb begin
      rd_value = '0;   // unknown address
      case (csr_req.addr)
         ADDR_SA_ENABLE: rd_value = 32'(sa_enable);
         ADDR_DA_ENABLE: rd_value = 32'(da_enable);
         ADDR_SIZE_DROP: rd_value = size_drop;
         ADDR_DA_DROP:   rd_value = da_drop;
         ADDR_SA_DROP:   rd_value = sa_drop;
         ADDR_CRC_DROP:  rd_value = crc_drop;
         default: begin
            for (int i = 0; i < NUM_PORTS; i++) begin
               if (csr_req.addr == ADDR_IN_COUNT_BASE + 8'(ADDR_COUNT_STRIDE * i)) begin
                  rd_value = in_count[i];
               end
               if (csr_req.addr == ADDR_OUT_COUNT_BASE + 8'(ADDR_COUNT_STRIDE * i)) begin
                  rd_value = out_count[i];
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         sa_enable <= '0;
         da_enable <= '0;
         size_drop <= '0;
         da_drop   <= '0;
         sa_drop   <= '0;
         crc_drop  <= '0;
         rdata     <= '0;
         for (int i = 0; i < NUM_PORTS; i++) begin
            in_count[i]  <= '0;
            out_count[i] <= '0;
         end
      end else begin
         if (csr_req.wr && csr_req.addr == ADDR_SA_ENABLE) begin
            sa_enable <= csr_req.wdata[NUM_PORTS-1:0];
         end
         if (csr_req.wr && csr_req.addr == ADDR_DA_ENABLE) begin
            da_enable <= csr_req.wdata[NUM_PORTS-1:0];
         end
         if (csr_req.rd) begin
            rdata <= rd_value;   // held until the next read
         end
         size_drop <= size_drop + 32'(n_size);
         da_drop   <= da_drop + 32'(n_da);
         sa_drop   <= sa_drop + 32'(n_sa);
         crc_drop  <= crc_drop + 32'(n_crc);
         for (int i = 0; i < NUM_PORTS; i++) begin
            in_count[i]  <= in_count[i] + 32'(rx_event[i].pkt_done);
            out_count[i] <= out_count[i] + 32'(out_done[i]);
         end
      end
   end

endmodule

// ==== rtl/switch_fabric.sv ====
/*
 * switch fabric: per output round-robin choice among the stores that
 * hold a packet for it, grant held from first to last beat
 */
`timescale 1ns/1ps

module switch_fabric
   import router_pkt_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  pkt_beat_t  tx_beat [NUM_PORTS],
   input  port_mask_t tx_valid,
   input  port_idx_t  dest [NUM_PORTS],
   output port_mask_t tx_ready,
   output pkt_beat_t  out_beat [NUM_PORTS],
   output port_mask_t out_valid,
   input  port_mask_t out_ready,
   output port_mask_t out_done
);

   port_mask_t busy;
   port_idx_t  grant [NUM_PORTS];
   port_idx_t  last_grant [NUM_PORTS];

   port_mask_t req [NUM_PORTS];   // req[out][in]
   port_idx_t  pick [NUM_PORTS];
   port_mask_t pick_valid;
   port_idx_t  sel [NUM_PORTS];
   port_mask_t active;

   always_comb begin : arb
      port_idx_t cand;
      for (int j = 0; j < NUM_PORTS; j++) begin
         for (int i = 0; i < NUM_PORTS; i++) begin
            req[j][i] = tx_valid[i] && dest[i] == port_idx_t'(j);
         end
         pick[j]       = last_grant[j];
         pick_valid[j] = 1'b0;
         // search starts just after the last winner
         for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = last_grant[j] + port_idx_t'(k);
            if (!pick_valid[j] && req[j][cand]) begin
               pick[j]       = cand;
               pick_valid[j] = 1'b1;
            end
         end
         sel[j]       = busy[j] ? grant[j] : pick[j];
         active[j]    = busy[j] | pick_valid[j];
         out_beat[j]  = tx_beat[sel[j]];
         out_valid[j] = active[j] & tx_valid[sel[j]];
         out_done[j]  = out_valid[j] & out_ready[j] & out_beat[j].last;
      end
   end

   always_comb begin
      tx_ready = '0;
      for (int j = 0; j < NUM_PORTS; j++) begin
         if (active[j]) begin
            tx_ready[sel[j]] = tx_ready[sel[j]] | out_ready[j];
         end
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy <= '0;
         for (int j = 0; j < NUM_PORTS; j++) begin
            grant[j]      <= '0;
            last_grant[j] <= port_idx_t'(NUM_PORTS - 1);   // input 0 first
         end
      end else begin
         for (int j = 0; j < NUM_PORTS; j++) begin
            if (!busy[j] && pick_valid[j]) begin
               grant[j]      <= pick[j];
               last_grant[j] <= pick[j];
            end
            if (out_done[j]) begin
               busy[j] <= 1'b0;
            end else if (pick_valid[j]) begin
               busy[j] <= 1'b1;   // hold through stalls
            end
         end
      end
   end

endmodule

// ==== rtl/packet_store.sv ====
/*
 * one-packet store: holds a committed packet and streams it out in order
 */
`timescale 1ns/1ps

module packet_store
   import router_pkt_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       wr_en,
   input  pkt_addr_t  wr_addr,
   input  logic [7:0] wr_data,
   input  logic       commit,
   input  port_idx_t  commit_dest,
   input  pkt_len_t   commit_len,
   output logic       full,
   output port_idx_t  dest,
   output pkt_beat_t  tx_beat,
   input  logic       tx_ready,
   output logic       tx_valid
);

   logic [7:0] mem [MAX_PKT_LEN];
   pkt_len_t   len_q;
   pkt_addr_t  rd_ptr;

   assign tx_valid     = full;
   assign tx_beat.data = mem[rd_ptr];
   assign tx_beat.last = pkt_len_t'(rd_ptr) == len_q - pkt_len_t'(1);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      if (commit) begin
         len_q <= commit_len;
         dest  <= commit_dest;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         full   <= 1'b0;
         rd_ptr <= '0;
      end else if (commit) begin
         full   <= 1'b1;
         rd_ptr <= '0;
      end else if (tx_valid && tx_ready) begin
         if (tx_beat.last) begin
            full <= 1'b0;   // receiver may refill next cycle
         end else begin
            rd_ptr <= rd_ptr + pkt_addr_t'(1);
         end
      end
   end

endmodule

// ==== rtl/packet_receiver.sv ====
/*
 * packet receiver: parses the header of one input, sums the payload,
 * writes bytes into its store and commits or drops the finished packet
 */
`timescale 1ns/1ps

module packet_receiver
   import router_pkt_pkg::*;
   import router_csr_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  pkt_beat_t  in_beat,
   input  logic       in_valid,
   output logic       in_ready,
   input  logic       port_enable,
   input  port_mask_t sa_enable,
   input  port_mask_t da_enable,
   input  logic       store_full,
   output logic       wr_en,
   output pkt_addr_t  wr_addr,
   output logic [7:0] wr_data,
   output logic       commit,
   output port_idx_t  commit_dest,
   output pkt_len_t   commit_len,
   output rx_event_t  event_out
);

   pkt_len_t    cnt_q;       // bytes taken so far, saturates past max
   logic        discard_q;   // rest of a packet from a disabled input
   logic [31:0] sum_q;
   logic [7:0]  sa_q;
   logic [7:0]  da_q;
   logic [31:0] len_q;
   logic [31:0] crc_q;

   logic        accept;
   logic        skip;
   logic        finish;
   pkt_len_t    n_bytes;
   logic [31:0] sum_next;
   port_idx_t   sa_idx;
   port_idx_t   da_idx;
   logic        size_ok;
   logic        da_ok;
   logic        sa_ok;
   logic        crc_ok;

   // also low in the commit cycle, before full rises, so byte 0 of the
   // next packet cannot overwrite the one just committed
   assign in_ready = ~store_full & ~commit;
   assign accept   = in_valid & in_ready;
   assign skip     = discard_q | (cnt_q == '0 && !port_enable);
   assign finish   = accept & ~skip & in_beat.last;
   assign n_bytes  = cnt_q + pkt_len_t'(1);
   assign sum_next = (cnt_q >= pkt_len_t'(HDR_LEN)) ? sum_q + 32'(in_beat.data) : sum_q;

   assign wr_en   = accept & ~skip & (cnt_q < pkt_len_t'(MAX_PKT_LEN));
   assign wr_addr = pkt_addr_t'(cnt_q);
   assign wr_data = in_beat.data;

   assign sa_idx  = port_idx_t'(sa_q - 8'd1);
   assign da_idx  = port_idx_t'(da_q - 8'd1);
   assign size_ok = len_q == 32'(n_bytes) && n_bytes >= pkt_len_t'(MIN_PKT_LEN) &&
                    n_bytes <= pkt_len_t'(MAX_PKT_LEN);
   assign da_ok   = da_q >= 8'd1 && da_q <= 8'(NUM_PORTS) && da_enable[da_idx];
   assign sa_ok   = sa_q >= 8'd1 && sa_q <= 8'(NUM_PORTS) && sa_enable[sa_idx];
   assign crc_ok  = sum_next == crc_q;   // includes the last byte

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cnt_q     <= '0;
         discard_q <= 1'b0;
         sum_q     <= '0;
         commit    <= 1'b0;
         event_out <= '0;
      end else begin
         commit    <= 1'b0;
         event_out <= '0;
         if (accept && skip) begin
            discard_q <= ~in_beat.last;
         end else if (finish) begin
            cnt_q              <= '0;
            sum_q              <= '0;
            event_out.pkt_done <= 1'b1;
            // first failing check wins
            if (!size_ok) begin
               event_out.size_drop <= 1'b1;
            end else if (!da_ok) begin
               event_out.da_drop <= 1'b1;
            end else if (!sa_ok) begin
               event_out.sa_drop <= 1'b1;
            end else if (!crc_ok) begin
               event_out.crc_drop <= 1'b1;
            end else begin
               commit <= 1'b1;
            end
         end else if (accept) begin
            if (cnt_q <= pkt_len_t'(MAX_PKT_LEN)) begin
               cnt_q <= n_bytes;
            end
            sum_q <= sum_next;
         end
      end
   end

   // header fields, length and checksum shift in lsb first
   always_ff @(posedge clk) begin
      if (accept && !skip) begin
         if (cnt_q == pkt_len_t'(0)) begin
            sa_q <= in_beat.data;
         end
         if (cnt_q == pkt_len_t'(1)) begin
            da_q <= in_beat.data;
         end
         if (cnt_q >= pkt_len_t'(LEN_FIELD_POS) && cnt_q < pkt_len_t'(LEN_FIELD_POS + 4)) begin
            len_q <= {in_beat.data, len_q[31:8]};
         end
         if (cnt_q >= pkt_len_t'(CRC_FIELD_POS) && cnt_q < pkt_len_t'(CRC_FIELD_POS + 4)) begin
            crc_q <= {in_beat.data, crc_q[31:8]};
         end
      end
      if (finish) begin
         commit_dest <= da_idx;
         commit_len  <= n_bytes;
      end
   end

endmodule

// ==== rtl/router_csr_pkg.sv ====
/*
 * router register map, register bus request and receiver event flags
 */
package router_csr_pkg;

   localparam logic [7:0] ADDR_SA_ENABLE      = 8'h20;
   localparam logic [7:0] ADDR_DA_ENABLE      = 8'h24;
   localparam logic [7:0] ADDR_SIZE_DROP      = 8'h32;
   localparam logic [7:0] ADDR_IN_COUNT_BASE  = 8'h36;
   localparam logic [7:0] ADDR_OUT_COUNT_BASE = 8'h52;
   localparam logic [7:0] ADDR_DA_DROP        = 8'h66;
   localparam logic [7:0] ADDR_SA_DROP        = 8'h70;
   localparam logic [7:0] ADDR_CRC_DROP       = 8'h94;

   localparam int ADDR_COUNT_STRIDE = 4;   // per port counters

   typedef struct packed {
      logic        wr;      // one cycle strobe
      logic        rd;      // one cycle strobe, never with wr
      logic [7:0]  addr;
      logic [31:0] wdata;
   } csr_req_t;

   // one cycle flags from a receiver at the end of a packet
   typedef struct packed {
      logic pkt_done;
      logic size_drop;
      logic da_drop;
      logic sa_drop;
      logic crc_drop;
   } rx_event_t;

endpackage

// ==== rtl/router_pkt_pkg.sv ====
/*
 * router packet format: port count, length limits, header field positions
 * and the byte-stream types shared by receiver, store and fabric
 */
package router_pkt_pkg;

   localparam int NUM_PORTS     = 4;
   localparam int MIN_PKT_LEN   = 14;
   localparam int MAX_PKT_LEN   = 64;
   localparam int HDR_LEN       = 10;   // sa, da, length, checksum
   localparam int LEN_FIELD_POS = 2;    // 4 bytes, lsb first
   localparam int CRC_FIELD_POS = 6;    // 4 bytes, lsb first

   typedef logic [NUM_PORTS-1:0]         port_mask_t;
   typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

   // byte index inside one store
   typedef logic [$clog2(MAX_PKT_LEN)-1:0] pkt_addr_t;

   // one wider than the address so a full 64 byte packet fits
   typedef logic [$clog2(MAX_PKT_LEN):0] pkt_len_t;

   typedef struct packed {
      logic [7:0] data;
      logic       last;   // final byte of the packet
   } pkt_beat_t;

endpackage
